// File: rtl/hub75_pkg.sv
`default_nettype none

package hub75_pkg;

    localparam int pixel_width      = 64;
    localparam int pixel_halfheight = 16;  // Rows per scanned half
    localparam int pixel_height     = 2 * pixel_halfheight;
    localparam int pixel_addr_width = 11;
    localparam int fb_depth         = pixel_width * pixel_height;

    localparam int col_width   = $clog2(pixel_width);
    localparam int row_width   = $clog2(pixel_halfheight);
    localparam int plane_count = 6;
    localparam int plane_width = $clog2(plane_count);

    localparam int col_cycles    = 4;  // clk_in cycles per shifted column
    localparam int slot_width    = $clog2(col_cycles);
    localparam int oe_unit       = 8;  // Display time of plane 0
    localparam int display_width = $clog2(oe_unit) + plane_count;
    localparam int blank_cycles  = 2;
    localparam int blank_width   = $clog2(blank_cycles + 1);

    // Wishbone address bit selecting the control register
    localparam int ctrl_reg_bit = 11;

    localparam logic [plane_count-1:0] brightness_enable_reset = '1;
    localparam logic [2:0]             rgb_enable_reset        = 3'b111;

    typedef logic [15:0] pixel_t;  // RGB565

    // 5-bit fields widen by repeating their top bit
    function automatic logic [plane_count-1:0] expand_red(pixel_t px);
        return {px[15:11], px[15]};
    endfunction

    function automatic logic [plane_count-1:0] expand_green(pixel_t px);
        return px[10:5];
    endfunction

    function automatic logic [plane_count-1:0] expand_blue(pixel_t px);
        return {px[4:0], px[4]};
    endfunction

endpackage

`default_nettype wire

// File: rtl/scan_if.sv
`timescale 1ns/100ps
`default_nettype none

interface scan_if;

    logic [5:0] column_address;
    logic [3:0] row_address;       // Row within the top half
    logic [2:0] plane;
    logic       pixel_load_start;  // First cycle of a column slot

    modport scanner (
        output column_address,
        output row_address,
        output plane,
        output pixel_load_start
    );

    modport fetcher (
        input column_address,
        input row_address,
        input plane,
        input pixel_load_start
    );

endinterface

`default_nettype wire

// File: rtl/wb_pixel_port.sv
`timescale 1ns/100ps
`default_nettype none

module wb_pixel_port import hub75_pkg::*; (
    input  wire                         clk_in,
    input  wire                         reset,
    input  wire                         wb_cyc,
    input  wire                         wb_stb,
    input  wire                         wb_we,
    input  wire [ctrl_reg_bit:0]        wb_adr,
    input  wire pixel_t                 wb_dat_w,
    input  wire [1:0]                   wb_sel,
    output logic [15:0]                 wb_dat_r,
    output logic                        wb_ack,
    output logic [pixel_addr_width-1:0] ram_address,
    output pixel_t                      ram_write_data,
    output logic                        ram_write_enable,
    output logic                        ram_read_enable,
    input  wire pixel_t                 ram_read_data,
    output logic [plane_count-1:0]      brightness_enable,
    output logic [2:0]                  rgb_enable
);

    logic                   request;      // Cycle open and not yet acknowledged
    logic                   write_cycle;
    logic                   ctrl_sel;
    logic [plane_count+2:0] ctrl_reg;     // {rgb_enable, brightness_enable}

    assign request     = wb_cyc & wb_stb & ~wb_ack;
    assign write_cycle = wb_ack & wb_cyc & wb_stb & wb_we;
    assign ctrl_sel    = wb_adr[ctrl_reg_bit];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= request;  // Single-cycle ack, one cycle after the request
        end
    end

    // Pixel read goes out with the request so its data lines up with ack
    assign ram_address      = wb_adr[pixel_addr_width-1:0];
    assign ram_write_data   = wb_dat_w;
    assign ram_read_enable  = request & ~wb_we & ~ctrl_sel;
    assign ram_write_enable = write_cycle & ~ctrl_sel & (&wb_sel);  // Whole pixels only

    always_ff @(posedge clk_in) begin
        if (reset) begin
            ctrl_reg <= {rgb_enable_reset, brightness_enable_reset};
        end else if (write_cycle && ctrl_sel) begin
            if (wb_sel[0]) begin
                ctrl_reg[7:0] <= wb_dat_w[7:0];  // Brightness plus red and green enables
            end
            if (wb_sel[1]) begin
                ctrl_reg[8] <= wb_dat_w[8];      // Blue enable
            end
        end
    end

    assign brightness_enable = ctrl_reg[plane_count-1:0];
    assign rgb_enable        = ctrl_reg[plane_count+2:plane_count];

    assign wb_dat_r = ctrl_sel ? 16'(ctrl_reg) : ram_read_data;

endmodule

`default_nettype wire

// File: rtl/framebuffer_ram.sv
`timescale 1ns/100ps
`default_nettype none

module framebuffer_ram import hub75_pkg::*; (
    input  wire                         clk_in,
    input  wire [pixel_addr_width-1:0]  a_address,
    input  wire pixel_t                 a_write_data,
    input  wire                         a_write_enable,
    input  wire                         a_read_enable,
    output pixel_t                      a_read_data,
    input  wire [pixel_addr_width-1:0]  b_address,
    input  wire                         b_read_enable,
    output pixel_t                      b_read_data
);

    pixel_t mem [fb_depth];  // Top half rows first, then bottom half

    // Host side
    always_ff @(posedge clk_in) begin
        if (a_write_enable) begin
            mem[a_address] <= a_write_data;
        end
        if (a_read_enable) begin
            a_read_data <= mem[a_address];
        end
    end

    always_ff @(posedge clk_in) begin
        if (b_read_enable) begin
            b_read_data <= mem[b_address];  // Scan side, read only
        end
    end

endmodule

`default_nettype wire

// File: rtl/matrix_scan.sv
`timescale 1ns/100ps
`default_nettype none

module matrix_scan import hub75_pkg::*; (
    input  wire                  clk_in,
    input  wire                  reset,
    scan_if.scanner              scan,
    output logic                 clk_pixel,
    output logic                 row_latch,
    output logic                 output_enable,
    output logic [row_width-1:0] row_address_active
);

    typedef enum logic [2:0] {
        st_shift,
        st_blank_pre,
        st_latch,
        st_blank_post,
        st_display
    } scan_state_t;

    scan_state_t              state;
    logic                     scan_run;       // Holds the sequencer for one cycle out of reset
    logic [slot_width-1:0]    slot_cycle;
    logic [col_width-1:0]     column;
    logic [row_width-1:0]     row;
    logic [plane_width-1:0]   plane;
    logic [blank_width-1:0]   blank_count;
    logic [display_width-1:0] display_timer;
    logic                     slot_end;
    logic                     last_blank;

    assign slot_end   = (slot_cycle == slot_width'(col_cycles - 1));
    assign last_blank = (blank_count == blank_width'(blank_cycles - 1));

    assign scan.column_address   = column;
    assign scan.row_address      = row;
    assign scan.plane            = plane;
    assign scan.pixel_load_start = scan_run && (state == st_shift) && (slot_cycle == '0);

    assign row_latch     = (state == st_latch);
    assign output_enable = (state == st_display);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            scan_run           <= 1'b0;
            state              <= st_shift;
            slot_cycle         <= '0;
            column             <= '0;
            row                <= '0;
            plane              <= '0;
            blank_count        <= '0;
            display_timer      <= '0;
            clk_pixel          <= 1'b0;
            row_address_active <= '0;
        end else begin
            scan_run <= 1'b1;
            // High for the cycle after the last slot cycle, once rgb has settled
            clk_pixel <= scan_run && (state == st_shift) && slot_end;
            if (scan_run) begin
                case (state)
                    st_shift: begin
                        slot_cycle <= slot_end ? '0 : slot_cycle + 1'b1;
                        if (slot_end) begin
                            column <= column + 1'b1;
                            if (column == col_width'(pixel_width - 1)) begin
                                column      <= '0;
                                blank_count <= '0;
                                state       <= st_blank_pre;
                            end
                        end
                    end
                    st_blank_pre: begin
                        blank_count <= blank_count + 1'b1;
                        if (last_blank) begin
                            state              <= st_latch;
                            row_address_active <= row;  // Panel row follows the latch
                        end
                    end
                    st_latch: begin
                        blank_count <= '0;
                        state       <= st_blank_post;
                    end
                    st_blank_post: begin
                        blank_count <= blank_count + 1'b1;
                        if (last_blank) begin
                            // Binary weighted on-time
                            display_timer <= (display_width'(oe_unit) << plane) - 1'b1;
                            state         <= st_display;
                        end
                    end
                    st_display: begin
                        display_timer <= display_timer - 1'b1;
                        if (display_timer == '0) begin
                            state <= st_shift;
                            if (plane == plane_width'(plane_count - 1)) begin
                                plane <= '0;
                                row   <= row + 1'b1;  // Wraps after the last row of the half
                            end else begin
                                plane <= plane + 1'b1;
                            end
                        end
                    end
                    default: state <= st_shift;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/framebuffer_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module framebuffer_fetch import hub75_pkg::*; (
    input  wire                         clk_in,
    input  wire                         reset,
    scan_if.fetcher                     scan,
    output logic [pixel_addr_width-1:0] ram_address,
    output logic                        ram_read_enable,
    input  wire pixel_t                 ram_read_data,
    input  wire [plane_count-1:0]       brightness_enable,
    input  wire [2:0]                   rgb_enable,
    output logic [2:0]                  rgb1,
    output logic [2:0]                  rgb2
);

    logic [pixel_addr_width-1:0] top_address;
    logic [pixel_addr_width-1:0] bottom_address;
    logic                        bottom_read;   // Slot cycle 1
    logic                        bottom_ready;  // Slot cycle 2, bottom pixel on the port
    logic [plane_width-1:0]      plane_q;
    pixel_t                      top_pixel;

    // Current plane's bit of each color as {blue, green, red}, masked
    function automatic logic [2:0] pixel_split(
        pixel_t                 px,
        logic [plane_width-1:0] plane,
        logic [plane_count-1:0] brightness,
        logic [2:0]             rgb_en
    );
        logic [plane_count-1:0] red;
        logic [plane_count-1:0] green;
        logic [plane_count-1:0] blue;
        red   = expand_red(px);
        green = expand_green(px);
        blue  = expand_blue(px);
        return {blue[plane], green[plane], red[plane]} & rgb_en & {3{brightness[plane]}};
    endfunction

    assign top_address = pixel_addr_width'(scan.row_address) * pixel_addr_width'(pixel_width)
                       + pixel_addr_width'(scan.column_address);

    // Top read on the load strobe, bottom read right behind it
    assign ram_read_enable = scan.pixel_load_start | bottom_read;
    assign ram_address     = bottom_read ? bottom_address : top_address;

    always_ff @(posedge clk_in) begin
        if (scan.pixel_load_start) begin
            bottom_address <= top_address + pixel_addr_width'(pixel_halfheight * pixel_width);
            plane_q        <= scan.plane;  // Used two cycles later
        end
        if (bottom_read) begin
            top_pixel <= ram_read_data;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            bottom_read  <= 1'b0;
            bottom_ready <= 1'b0;
            rgb1         <= '0;
            rgb2         <= '0;
        end else begin
            bottom_read  <= scan.pixel_load_start;
            bottom_ready <= bottom_read;
            if (bottom_ready) begin
                rgb1 <= pixel_split(top_pixel, plane_q, brightness_enable, rgb_enable);
                rgb2 <= pixel_split(ram_read_data, plane_q, brightness_enable, rgb_enable);
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/hub75_top.sv
`timescale 1ns/100ps
`default_nettype none

module hub75_top (
    input  wire        clk_in,
    input  wire        reset,
    input  wire        wb_cyc,
    input  wire        wb_stb,
    input  wire        wb_we,
    input  wire [11:0] wb_adr,
    input  wire [15:0] wb_dat_w,
    input  wire [1:0]  wb_sel,
    output wire [15:0] wb_dat_r,
    output wire        wb_ack,
    output wire [2:0]  rgb1,         // Top half {B, G, R}
    output wire [2:0]  rgb2,         // Bottom half
    output wire [3:0]  row_address,  // A to D
    output wire        clk_pixel,
    output wire        row_latch,
    output wire        output_enable_n
);

    wire [10:0] a_address;
    wire [15:0] a_write_data;
    wire        a_write_enable;
    wire        a_read_enable;
    wire [15:0] a_read_data;
    wire [10:0] b_address;
    wire        b_read_enable;
    wire [15:0] b_read_data;
    wire [5:0]  brightness_enable;
    wire [2:0]  rgb_enable;
    wire        output_enable;

    scan_if scan ();

    wb_pixel_port u_wb_pixel_port (
        .*,
        .ram_address      (a_address),
        .ram_write_data   (a_write_data),
        .ram_write_enable (a_write_enable),
        .ram_read_enable  (a_read_enable),
        .ram_read_data    (a_read_data)
    );

    framebuffer_ram u_framebuffer_ram (.*);

    matrix_scan u_matrix_scan (
        .*,
        .row_address_active (row_address)
    );

    framebuffer_fetch u_framebuffer_fetch (
        .*,
        .ram_address     (b_address),
        .ram_read_enable (b_read_enable),
        .ram_read_data   (b_read_data)
    );

    assign output_enable_n = ~output_enable;  // Panel OE is active low

endmodule

`default_nettype wire

// File: tests/tb_hub75.sv
`timescale 1ns/100ps
`default_nettype none

module tb_hub75 import hub75_pkg::*; ();

    typedef struct packed {
        logic        we;
        logic [11:0] adr;
        logic [15:0] data;
        logic [1:0]  sel;
        logic [15:0] expected;  // Expected read data
    } bus_entry_t;

    logic        clk_in;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [11:0] wb_adr;
    logic [15:0] wb_dat_w;
    logic [1:0]  wb_sel;
    logic [15:0] wb_dat_r;
    logic        wb_ack;
    logic [2:0]  rgb1;
    logic [2:0]  rgb2;
    logic [3:0]  row_address;
    logic        clk_pixel;
    logic        row_latch;
    logic        output_enable_n;

    logic [15:0] ref_fb [pixel_width * pixel_halfheight * 2];  // Mirror of the framebuffer
    bus_entry_t  bus_table [8];
    logic [5:0]  bright_model;
    logic [2:0]  rgb_model;
    logic [2:0]  top_bits [pixel_width];     // Top half of the panel shift register
    logic [2:0]  bottom_bits [pixel_width];
    logic        clk_pixel_q;
    logic        data_armed;                 // Checks start at the next latch
    logic        data_check;
    logic [15:0] read_data;
    int          shift_count;
    int          oe_count;
    int          latch_count;
    int          error_count;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    integer      seed;

    hub75_top u_hub75_top (.*);

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, expected);
        error_count++;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        error_count++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_count != test_errors) begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, error_count - test_errors);
        end else begin
            $display("test %s passed", name);
        end
        test_errors = error_count;
    endtask

    // Red and blue widen to 6 bits by repeating their top bit
    function automatic logic [2:0] expected_bits(input logic [15:0] px, input int plane);
        logic [5:0] red;
        logic [5:0] green;
        logic [5:0] blue;
        red   = {px[15:11], px[15]};
        green = px[10:5];
        blue  = {px[4:0], px[4]};
        return {blue[plane], green[plane], red[plane]} & rgb_model & {3{bright_model[plane]}};
    endfunction

    task automatic bus_cycle(input logic we, input logic [11:0] adr, input logic [15:0] data,
                             input logic [1:0] sel, output logic [15:0] rdata);
        int wait_cycles;
        wait_cycles = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        wb_sel   = sel;
        do begin
            @(negedge clk_in);
            wait_cycles++;
        end while (!wb_ack && wait_cycles < 16);
        if (!wb_ack) begin
            report_timeout("no Wishbone ack within 16 cycles");
        end else begin
            if (wait_cycles != 1) flag_mismatch("wb_ack latency", wait_cycles, 1);
        end
        rdata = wb_dat_r;
        @(negedge clk_in);  // Write lands on the ack cycle
        if (wb_ack) flag_mismatch("wb_ack after ack cycle", wb_ack, 0);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wait_latches(input int count);
        int target;
        int wait_cycles;
        target      = latch_count + count;
        wait_cycles = 0;
        while (latch_count < target && wait_cycles < count * 1000) begin
            @(negedge clk_in);
            wait_cycles++;
        end
        if (latch_count < target) report_timeout("row latch stopped arriving");
    endtask

    task automatic check_latch();
        int plane;
        int row;
        int oe_expected;
        int base;
        plane       = latch_count % plane_count;
        row         = (latch_count / plane_count) % pixel_halfheight;
        oe_expected = (latch_count == 0) ? 0 : oe_unit << ((latch_count - 1) % plane_count);
        base        = row * pixel_width;
        if (output_enable_n !== 1'b1)
            flag_mismatch("output_enable_n at latch", output_enable_n, 1);
        if (row_address !== 4'(row)) flag_mismatch("row_address", row_address, row);
        if (shift_count != pixel_width) flag_mismatch("shifted columns", shift_count, pixel_width);
        if (oe_count != oe_expected) flag_mismatch("output enable cycles", oe_count, oe_expected);
        if (data_check) begin
            for (int col = 0; col < pixel_width; col++) begin
                if (top_bits[col] !== expected_bits(ref_fb[base + col], plane))
                    flag_mismatch("rgb1", top_bits[col], expected_bits(ref_fb[base + col], plane));
                if (bottom_bits[col] !== expected_bits(ref_fb[base + 1024 + col], plane))
                    flag_mismatch("rgb2", bottom_bits[col],
                                  expected_bits(ref_fb[base + 1024 + col], plane));
            end
        end
        data_check = data_armed;
        latch_count++;
        shift_count = 0;
        oe_count    = 0;
    endtask

    // Panel model sampled away from the active clock edge
    always @(negedge clk_in) begin
        if (reset) begin
            shift_count = 0;
            oe_count    = 0;
            latch_count = 0;
            clk_pixel_q = 1'b0;
            data_check  = 1'b0;
        end else begin
            if (clk_pixel && !clk_pixel_q) begin
                if (shift_count < pixel_width) begin
                    top_bits[shift_count]    = rgb1;
                    bottom_bits[shift_count] = rgb2;
                end
                shift_count++;
            end
            clk_pixel_q = clk_pixel;
            if (!output_enable_n) oe_count++;
            if (row_latch) check_latch();
        end
    end

    initial begin
        seed         = 32'haf02;
        error_count  = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        data_armed   = 1'b0;
        bright_model = 6'h3f;
        rgb_model    = 3'b111;
        reset        = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        wb_sel       = '0;
        bus_table[0] = {1'b1, 12'h005, 16'ha5c3, 2'b11, 16'h0000};
        bus_table[1] = {1'b0, 12'h005, 16'h0000, 2'b11, 16'ha5c3};
        bus_table[2] = {1'b1, 12'h005, 16'h1234, 2'b01, 16'h0000};  // Partial select is ignored
        bus_table[3] = {1'b0, 12'h005, 16'h0000, 2'b11, 16'ha5c3};
        bus_table[4] = {1'b1, 12'h7ff, 16'h5aa5, 2'b11, 16'h0000};
        bus_table[5] = {1'b0, 12'h7ff, 16'h0000, 2'b11, 16'h5aa5};
        bus_table[6] = {1'b1, 12'h005, 16'h1234, 2'b10, 16'h0000};
        bus_table[7] = {1'b0, 12'h005, 16'h0000, 2'b11, 16'ha5c3};

        repeat (8) @(negedge clk_in);
        if (output_enable_n !== 1'b1) flag_mismatch("output_enable_n", output_enable_n, 1);
        if (row_latch !== 1'b0) flag_mismatch("row_latch", row_latch, 0);
        if (wb_ack !== 1'b0) flag_mismatch("wb_ack", wb_ack, 0);
        reset = 1'b0;
        bus_cycle(1'b0, 12'h800, 16'h0000, 2'b11, read_data);
        if (read_data !== 16'h01ff) flag_mismatch("wb_dat_r control", read_data, 16'h01ff);
        finish_test("reset values");

        for (int i = 0; i < 8; i++) begin
            bus_cycle(bus_table[i].we, bus_table[i].adr, bus_table[i].data, bus_table[i].sel,
                      read_data);
            if (!bus_table[i].we && read_data !== bus_table[i].expected)
                flag_mismatch("wb_dat_r", read_data, bus_table[i].expected);
        end
        finish_test("register access table");

        for (int addr = 0; addr < 2048; addr++) begin
            ref_fb[addr] = 16'($random(seed));
            bus_cycle(1'b1, 12'(addr), ref_fb[addr], 2'b11, read_data);
        end
        for (int addr = 0; addr < 2048; addr += 97) begin
            bus_cycle(1'b0, 12'(addr), 16'h0000, 2'b11, read_data);
            if (read_data !== ref_fb[addr]) flag_mismatch("wb_dat_r", read_data, ref_fb[addr]);
        end
        finish_test("frame fill");

        data_armed = 1'b1;
        wait_latches(plane_count * pixel_halfheight + 1);  // One whole frame of planes
        finish_test("frame scan");

        data_armed = 1'b0;
        data_check = 1'b0;
        // Green and plane 3 off, blue enable byte not selected
        bus_cycle(1'b1, 12'h800, 16'h0077, 2'b01, read_data);
        bright_model    = 6'h37;
        rgb_model[1:0]  = 2'b01;
        bus_cycle(1'b0, 12'h800, 16'h0000, 2'b11, read_data);
        if (read_data !== 16'h0177) flag_mismatch("wb_dat_r control", read_data, 16'h0177);
        data_armed = 1'b1;
        wait_latches(plane_count * 2 + 1);
        finish_test("color masking");

        // Rewrite the same pixels back to back while the scan runs
        for (int addr = 0; addr < 2048; addr++) begin
            bus_cycle(1'b1, 12'(addr), ref_fb[addr], 2'b11, read_data);
        end
        wait_latches(1);
        finish_test("writes during scan");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
rtl/hub75_pkg.sv
rtl/scan_if.sv
rtl/wb_pixel_port.sv
rtl/framebuffer_ram.sv
rtl/matrix_scan.sv
rtl/framebuffer_fetch.sv
rtl/hub75_top.sv
tests/tb_hub75.sv
